/* verilog/kicker_pkg.sv */
// Shared definitions for the kicker voltage monitor.
// Bit timing, ADC addressing, controller types and host sample layout.

package kicker_pkg;

	//////////////////////////////////////////////////////////////
	// i2c bit timing, in sysclk cycles.
	//////////////////////////////////////////////////////////////
	localparam int scl_period = 46;
	localparam int scl_fall = 22;
	localparam int scl_start = 10;
	localparam int scl_setup = 33;

	// voltage adc address with the read bit set.
	localparam logic [7:0] adc_select = 8'ha1;

	//////////////////////////////////////////////////////////////
	// controller and shifter types.
	//////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		st_start,
		st_slave_addr,
		st_slave_ack,
		st_data_high,
		st_master_ack,
		st_data_low,
		st_master_nack,
		st_stop
	} i2c_state_t;

	typedef enum logic [1:0] {
		sda_release,
		sda_low,
		sda_addr
	} sda_cmd_t;

	// one-cycle strobes at fixed points inside each bit.
	typedef struct packed {
		logic bit_begin;
		logic sample;
		logic start_point;
		logic setup_point;
	} i2c_phase_t;

	typedef struct packed {
		logic [7:0] voltage;
		logic [7:0] dropped;
	} kicker_sample_t;

endpackage

/* verilog/i2c_phase_gen.sv */
// I2C bit timer.
// Divides sysclk into bit periods, drives SCL and decodes the phase strobes.

module i2c_phase_gen import kicker_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	output logic       scl_out,
	output i2c_phase_t phase
);

	logic [5:0] div_count;

	//////////////////////////////////////////////////////////////
	// free running bit divider.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (reset) begin
			div_count <= '0;
		end else if (div_count == 6'(scl_period - 1)) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 6'd1;
		end
	end

	// strobes are plain decodes of the divider.
	always_comb begin
		phase.bit_begin = (div_count == 6'd0);
		phase.sample = (div_count == 6'd1);
		phase.start_point = (div_count == 6'(scl_start));
		phase.setup_point = (div_count == 6'(scl_setup));
	end

	//////////////////////////////////////////////////////////////
	// scl is high for the first part of every bit.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (reset) begin
			scl_out <= 1'b1;
		end else if (phase.bit_begin) begin
			scl_out <= 1'b1;
		end else if (div_count == 6'(scl_fall)) begin
			// data may change from here until the next bit begins.
			scl_out <= 1'b0;
		end
	end

endmodule

/* verilog/i2c_shifter.sv */
// I2C data path.
// Drives SDA from controller commands and shifts the address out and the data word in.

module i2c_shifter import kicker_pkg::*; (
	input  logic        sysclk,
	input  logic        reset,
	input  logic        sda_in,
	input  logic        load_addr,
	input  logic        shift_addr,
	input  logic        capture_bit,
	input  sda_cmd_t    sda_cmd,
	input  i2c_phase_t  phase,
	output logic        sda_out,
	output logic        sda_sync,
	output logic [15:0] data_word
);

	logic [7:0] addr_sr;
	logic       addr_bit;

	// when shifting, the bit moving into the msb is the one to drive.
	assign addr_bit = shift_addr ? addr_sr[6] : addr_sr[7];

	//////////////////////////////////////////////////////////////
	// input sync and sda drive.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (reset) begin
			sda_sync <= 1'b1;
			sda_out <= 1'b1;
		end else begin
			sda_sync <= sda_in;
			// sda only moves at the start and setup points.
			if (phase.start_point || phase.setup_point) begin
				case (sda_cmd)
					sda_low: sda_out <= 1'b0;
					sda_addr: sda_out <= addr_bit;
					default: sda_out <= 1'b1;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// shift registers.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (load_addr) begin
			addr_sr <= adc_select;
		end else if (shift_addr) begin
			addr_sr <= {addr_sr[6:0], 1'b0};
		end
	end

	// data arrives msb first, high byte then low byte.
	always_ff @(posedge sysclk) begin
		if (capture_bit) begin
			data_word <= {data_word[14:0], sda_sync};
		end
	end

endmodule

/* verilog/i2c_ctrl.sv */
// I2C read transaction controller.
// Sequences start, address, acks, two data bytes and stop on the phase strobes.

module i2c_ctrl import kicker_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	input  i2c_phase_t phase,
	input  logic       sda_sync,
	output sda_cmd_t   sda_cmd,
	output logic       load_addr,
	output logic       shift_addr,
	output logic       capture_bit,
	output logic       word_done,
	output logic       slave_ok
);

	i2c_state_t state;
	i2c_state_t next_state;
	logic [2:0] bit_cnt;
	logic       last_bit;

	assign last_bit = (bit_cnt == 3'd7);

	// steady sda level for the whole of a bit in the given state.
	function automatic sda_cmd_t bit_cmd(input i2c_state_t st);
		case (st)
			st_slave_addr: return sda_addr;
			st_master_ack: return sda_low;
			st_stop: return sda_low;
			default: return sda_release;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////
	// state to enter when the current bit ends.
	//////////////////////////////////////////////////////////////
	always_comb begin
		case (state)
			st_start: next_state = st_slave_addr;
			st_slave_addr: next_state = last_bit ? st_slave_ack : st_slave_addr;
			st_slave_ack: next_state = slave_ok ? st_data_high : st_start;
			st_data_high: next_state = last_bit ? st_master_ack : st_data_high;
			st_master_ack: next_state = st_data_low;
			st_data_low: next_state = last_bit ? st_master_nack : st_data_low;
			st_master_nack: next_state = st_stop;
			default: next_state = st_start;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// state, bit counter and slave ack.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= st_start;
			bit_cnt <= '0;
			slave_ok <= 1'b0;
		end else begin
			if (phase.sample && state == st_slave_ack) begin
				// slave pulls sda low to acknowledge.
				slave_ok <= ~sda_sync;
			end
			if (phase.setup_point) begin
				state <= next_state;
				if (next_state != state) begin
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 3'd1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// shifter commands.
	//////////////////////////////////////////////////////////////
	// start and stop transitions happen at the start point with scl high.
	// at the setup point sda takes the level of the bit that follows.
	always_comb begin
		if (phase.start_point) begin
			case (state)
				st_start: sda_cmd = sda_low;
				st_stop: sda_cmd = sda_release;
				default: sda_cmd = bit_cmd(state);
			endcase
		end else begin
			sda_cmd = bit_cmd(next_state);
		end
	end

	assign load_addr = phase.start_point && (state == st_start);
	assign shift_addr = phase.setup_point && (state == st_slave_addr) && !last_bit;
	assign capture_bit = phase.sample && (state == st_data_high || state == st_data_low);
	assign word_done = phase.setup_point && (state == st_master_nack);

endmodule

/* verilog/sample_port.sv */
// Host sample port.
// Holds each finished voltage and hands it over by four-phase req/ack, counting drops.

module sample_port import kicker_pkg::*; (
	input  logic           sysclk,
	input  logic           reset,
	input  logic           word_done,
	input  logic           sample_ack,
	input  logic [15:0]    data_word,
	output logic           sample_req,
	output kicker_sample_t sample_data
);

	typedef enum logic [1:0] {
		port_idle,
		port_req,
		port_release
	} port_state_t;

	port_state_t state;
	logic [7:0]  drop_cnt;

	assign sample_req = (state == port_req);

	//////////////////////////////////////////////////////////////
	// handshake FSM and drop counter.
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= port_idle;
			drop_cnt <= '0;
		end else begin
			case (state)
				port_idle: begin
					if (word_done) begin
						drop_cnt <= '0;
						state <= port_req;
					end
				end
				port_req: begin
					if (sample_ack) begin
						state <= port_release;
					end
				end
				default: begin
					// wait for the host to finish its side.
					if (!sample_ack) begin
						state <= port_idle;
					end
				end
			endcase
			// words finishing while busy are lost.
			if (word_done && state != port_idle && drop_cnt != 8'hff) begin
				drop_cnt <= drop_cnt + 8'd1;
			end
		end
	end

	// payload only changes when a new request is raised.
	always_ff @(posedge sysclk) begin
		if (state == port_idle && word_done) begin
			sample_data.voltage <= data_word[11:4];
			sample_data.dropped <= drop_cnt;
		end
	end

endmodule

/* verilog/kicker_monitor.sv */
// Kicker voltage monitor top level.
// Reads the kicker I2C ADC in a loop and offers each voltage to the host.

module kicker_monitor import kicker_pkg::*; (
	input  logic           sysclk,
	input  logic           reset,
	input  logic           sda_in,
	input  logic           sample_ack,
	output logic           scl_out,
	output logic           sda_out,
	output logic           slave_ok,
	output logic           sample_req,
	output kicker_sample_t sample_data
);

	i2c_phase_t  phase;
	sda_cmd_t    sda_cmd;
	logic        load_addr;
	logic        shift_addr;
	logic        capture_bit;
	logic        word_done;
	logic        sda_sync;
	logic [15:0] data_word;

	i2c_phase_gen i2c_phase_gen_i (
		.sysclk (sysclk),
		.reset  (reset),
		.scl_out(scl_out),
		.phase  (phase)
	);

	i2c_shifter i2c_shifter_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.sda_in     (sda_in),
		.load_addr  (load_addr),
		.shift_addr (shift_addr),
		.capture_bit(capture_bit),
		.sda_cmd    (sda_cmd),
		.phase      (phase),
		.sda_out    (sda_out),
		.sda_sync   (sda_sync),
		.data_word  (data_word)
	);

	i2c_ctrl i2c_ctrl_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.phase      (phase),
		.sda_sync   (sda_sync),
		.sda_cmd    (sda_cmd),
		.load_addr  (load_addr),
		.shift_addr (shift_addr),
		.capture_bit(capture_bit),
		.word_done  (word_done),
		.slave_ok   (slave_ok)
	);

	sample_port sample_port_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.word_done  (word_done),
		.sample_ack (sample_ack),
		.data_word  (data_word),
		.sample_req (sample_req),
		.sample_data(sample_data)
	);

endmodule

/* tests/i2c_adc_model.sv */
// Behavioral I2C voltage ADC slave.
// Acknowledges or refuses its address and serves one 16-bit word per read.

module i2c_adc_model (
	input  logic        sysclk,
	input  logic        reset,
	input  logic        scl,
	input  logic        sda,
	input  logic [15:0] next_word,
	input  logic        next_accept,
	output logic        sda_drive,
	output logic        report,
	output logic [7:0]  report_addr,
	output logic        report_acked,
	output logic [15:0] report_word
);

	typedef enum {m_idle, m_addr, m_ack, m_data, m_mack} model_state_t;

	model_state_t state;
	logic        scl_q;
	logic        sda_q;
	logic [7:0]  addr;
	logic [3:0]  cnt;
	logic [4:0]  di;
	logic [15:0] word;
	logic        accept;

	//////////////////////////////////////////////////////////////
	// bus is sampled on sysclk, edges are found from the last sample.
	//////////////////////////////////////////////////////////////
	always @(posedge sysclk) begin
		report <= 1'b0;
		if (reset) begin
			state <= m_idle;
			sda_drive <= 1'b1;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin
				// start condition, the next read begins here.
				state <= m_addr;
				cnt <= '0;
				word <= next_word;
				accept <= next_accept;
				sda_drive <= 1'b1;
			end else if (scl && scl_q && !sda_q && sda) begin
				state <= m_idle;
				sda_drive <= 1'b1;
			end else if (scl && !scl_q) begin
				if (state == m_addr) begin
					addr <= {addr[6:0], sda};
					cnt <= cnt + 4'd1;
				end
			end else if (!scl && scl_q) begin
				case (state)
					m_addr: begin
						if (cnt == 4'd8) begin
							report_addr <= addr;
							if (addr == 8'ha1 && accept) begin
								sda_drive <= 1'b0;
								state <= m_ack;
							end else begin
								// refused, leave sda released for the ack bit.
								sda_drive <= 1'b1;
								report <= 1'b1;
								report_acked <= 1'b0;
								state <= m_idle;
							end
						end
					end
					m_ack: begin
						sda_drive <= word[15];
						di <= 5'd1;
						state <= m_data;
					end
					m_data: begin
						if (di == 5'd8 || di == 5'd16) begin
							sda_drive <= 1'b1;
							state <= m_mack;
						end else begin
							sda_drive <= word[15 - di];
							di <= di + 5'd1;
						end
					end
					m_mack: begin
						if (di == 5'd8) begin
							sda_drive <= word[7];
							di <= 5'd9;
							state <= m_data;
						end else begin
							// master nack bit is over, the word is served.
							sda_drive <= 1'b1;
							report <= 1'b1;
							report_acked <= 1'b1;
							report_word <= word;
							state <= m_idle;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* tests/tb_kicker_monitor.sv */
// Testbench for the kicker voltage monitor.
// Runs the DUT against an ADC model and checks each host sample against a reference queue.

module tb_kicker_monitor import kicker_pkg::*; ();

	localparam int wait_limit = 20000;

	logic           sysclk;
	logic           reset;
	logic           sda_in;
	logic           sample_ack;
	logic           scl_out;
	logic           sda_out;
	logic           slave_ok;
	logic           sample_req;
	kicker_sample_t sample_data;
	logic           model_drive;
	logic [15:0]    next_word;
	logic           next_accept;
	logic           report;
	logic [7:0]     report_addr;
	logic           report_acked;
	logic [15:0]    report_word;
	logic [31:0]    lfsr_state;
	logic [15:0]    acked_q[$];
	logic           scl_q;
	logic           sda_q;
	logic           req_q;
	kicker_sample_t data_q;
	int             errors;
	int             checks;
	int             start_count;
	int             report_count;
	int             refused_count;
	int             delivered;
	int             dropped_sum;
	int             consumed;
	bit             random_mode;
	bit             timed_out;

	// open collector bus where either side can pull low.
	assign sda_in = sda_out & model_drive;

	kicker_monitor kicker_monitor_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.sda_in     (sda_in),
		.sample_ack (sample_ack),
		.scl_out    (scl_out),
		.sda_out    (sda_out),
		.slave_ok   (slave_ok),
		.sample_req (sample_req),
		.sample_data(sample_data)
	);

	i2c_adc_model adc_model_i (
		.sysclk      (sysclk),
		.reset       (reset),
		.scl         (scl_out),
		.sda         (sda_in),
		.next_word   (next_word),
		.next_accept (next_accept),
		.sda_drive   (model_drive),
		.report      (report),
		.report_addr (report_addr),
		.report_acked(report_acked),
		.report_word (report_word)
	);

	initial begin
		sysclk = 1'b0;
		forever #4 sysclk = ~sysclk;
	end

	//////////////////////////////////////////////////////////////
	// random numbers and checks.
	//////////////////////////////////////////////////////////////
	// 32-bit fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	task automatic report_test(input int num, input string name, input int err0);
		if (errors == err0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - err0);
		end
	endtask

	task automatic wait_req(input logic level, input string what);
		int n;
		n = 0;
		while (sample_req !== level && n < wait_limit) begin
			@(negedge sysclk);
			n++;
		end
		if (sample_req !== level) begin
			timed_out = 1'b1;
			$display("timeout while waiting for %s", what);
		end
	endtask

	// one full host handshake checked against the newest acked word.
	// the host holds ack for the same delay before and after the request drops.
	task automatic take_sample(input int delay);
		logic [15:0] exp;
		int size;
		if (timed_out) return;
		wait_req(1'b1, "sample_req to rise");
		if (timed_out) return;
		check_value("slave_ok", slave_ok, 1);
		size = acked_q.size();
		if (size == 0) begin
			check_true(1'b0, "sample delivered without an acknowledged read");
		end else begin
			exp = acked_q[size - 1];
			check_value("sample_data.voltage", sample_data.voltage, exp[11:4]);
			check_value("sample_data.dropped", sample_data.dropped, (size > 256) ? 255 : size - 1);
			consumed += size;
			delivered++;
			dropped_sum += sample_data.dropped;
			acked_q.delete();
		end
		repeat (delay) @(posedge sysclk);
		@(posedge sysclk);
		sample_ack <= 1'b1;
		wait_req(1'b0, "sample_req to fall");
		if (timed_out) return;
		repeat (delay) @(posedge sysclk);
		@(posedge sysclk);
		sample_ack <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////
	// reference queue fed by the model, bus and handshake monitors.
	//////////////////////////////////////////////////////////////
	always @(posedge sysclk) begin
		logic [31:0] v;
		if (!reset && report) begin
			report_count++;
			check_value("report_addr", report_addr, 8'ha1);
			if (report_acked) begin
				acked_q.push_back(report_word);
			end else begin
				refused_count++;
			end
			draw_bits(16, v);
			next_word <= v[15:0];
			if (random_mode) begin
				draw_bits(2, v);
				next_accept <= (v[1:0] != 2'd0);
			end else begin
				next_accept <= 1'b1;
			end
		end
	end

	always @(posedge sysclk) begin
		scl_q <= scl_out;
		sda_q <= sda_in;
		req_q <= sample_req;
		data_q <= sample_data;
		if (!reset) begin
			// sda falling while scl stays high.
			if (scl_out && scl_q && sda_q && !sda_in) begin
				start_count++;
			end
			if (sample_req && !req_q) begin
				check_true(!sample_ack, "sample_req rose while sample_ack was still high");
			end
			if (sample_req && req_q) begin
				check_value("sample_data", data_q, sample_data);
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// test sequence.
	//////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] v;
		int n;
		int e0;
		int mark;
		int c0;
		int d0;
		int s0;
		lfsr_state = 32'hc8dee3ea;
		reset = 1'b1;
		sample_ack = 1'b0;
		random_mode = 1'b0;
		timed_out = 1'b0;
		draw_bits(16, v);
		next_word = v[15:0];
		next_accept = 1'b1;
		repeat (8) @(posedge sysclk);
		reset <= 1'b0;

		@(negedge sysclk);
		e0 = errors;
		check_value("scl_out", scl_out, 1);
		check_value("sda_out", sda_out, 1);
		check_value("sample_req", sample_req, 0);
		check_value("slave_ok", slave_ok, 0);
		report_test(1, "reset state", e0);

		e0 = errors;
		n = 0;
		while ((start_count == 0 || report_count == 0) && n < wait_limit) begin
			@(negedge sysclk);
			n++;
		end
		if (start_count == 0 || report_count == 0) begin
			timed_out = 1'b1;
			$display("timeout while waiting for the first start and address byte");
		end
		report_test(2, "start and address", e0);

		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			take_sample(0);
			if (!timed_out) begin
				check_value("sample_data.dropped", sample_data.dropped, 0);
			end
		end
		report_test(3, "prompt host acks", e0);

		// the next read is refused and the one after it is accepted again.
		e0 = errors;
		if (!timed_out) begin
			@(posedge sysclk);
			next_accept <= 1'b0;
			mark = refused_count;
			n = 0;
			while (refused_count == mark && n < wait_limit) begin
				@(negedge sysclk);
				check_true(!sample_req, "sample offered during a refused read");
				n++;
			end
			mark = start_count;
			while (start_count == mark && n < wait_limit) begin
				@(negedge sysclk);
				check_true(!sample_req, "sample offered for a refused read");
				n++;
			end
			if (n >= wait_limit) begin
				timed_out = 1'b1;
				$display("timeout while waiting for the refused read to restart");
			end else begin
				check_value("slave_ok", slave_ok, 0);
				take_sample(0);
			end
		end
		report_test(4, "refused address", e0);

		e0 = errors;
		random_mode = 1'b1;
		c0 = consumed;
		d0 = delivered;
		s0 = dropped_sum;
		for (int i = 0; i < 8; i++) begin
			@(negedge sysclk);
			draw_bits(12, v);
			take_sample(int'(v[11:0]));
		end
		if (!timed_out) begin
			check_value("delivered plus dropped", (delivered - d0) + (dropped_sum - s0),
				consumed - c0);
		end
		report_test(5, "random host delays", e0);

		$display("checks %0d errors %0d delivered %0d dropped %0d", checks, errors, delivered,
			dropped_sum);
		if (timed_out || errors != 0) begin
			$display("TESTBENCH FAILED");
		end else begin
			$display("TESTBENCH PASSED");
		end
		$finish;
	end

endmodule

/* vlog.f */
verilog/kicker_pkg.sv
verilog/i2c_phase_gen.sv
verilog/i2c_shifter.sv
verilog/i2c_ctrl.sv
verilog/sample_port.sv
verilog/kicker_monitor.sv
tests/i2c_adc_model.sv
tests/tb_kicker_monitor.sv
